// File: Bender.yml
package:
  name: mbox

sources:
  - common/mbox_pkg.sv
  - cdc_fifo/afifo.sv
  - hdl/mbox_axil_regs.sv
  - hdl/mbox_top.sv
  - target: test
    files:
      - verif/mbox_tb.sv

// File: cdc_fifo/afifo.sv
module afifo #(
	parameter type T_PAYLOAD = logic [7:0],
	parameter int  AW        = 4
) (
	input  logic     i_wclk,
	input  logic     i_wrst_n,
	input  logic     i_wr,
	input  T_PAYLOAD i_wdata,
	output logic     o_wfull,
	input  logic     i_rclk,
	input  logic     i_rrst_n,
	input  logic     i_rd,
	output T_PAYLOAD o_rdata,
	output logic     o_rempty
);

	localparam int DEPTH = 1 << AW;

	// Payload storage written on i_wclk
	T_PAYLOAD mem [DEPTH];

	// Write side pointers carry one extra bit that tells a wrap from a match
	logic [AW:0] wbin;
	logic [AW:0] wgray;
	logic [AW:0] wbin_next;
	logic [AW:0] wgray_next;
	logic        wr_ok;

	// Read pointer as seen from the write domain
	logic [AW:0] wq1_rgray;
	logic [AW:0] wq2_rgray;

	// Read side pointers
	logic [AW:0] rbin;
	logic [AW:0] rgray;
	logic [AW:0] rbin_next;
	logic [AW:0] rgray_next;
	logic        rd_ok;

	// Write pointer as seen from the read domain
	logic [AW:0] rq1_wgray;
	logic [AW:0] rq2_wgray;

	////////////////////
	// Write domain
	////////////////////

	// A push into a full FIFO is dropped here
	assign wr_ok = i_wr && !o_wfull;

	assign wbin_next  = wbin + {{AW{1'b0}}, wr_ok};
	assign wgray_next = (wbin_next >> 1) ^ wbin_next;

	always_ff @(posedge i_wclk or negedge i_wrst_n) begin
		if (!i_wrst_n) begin
			wbin  <= '0;
			wgray <= '0;
		end else begin
			wbin  <= wbin_next;
			wgray <= wgray_next;
		end
	end

	// Two flop synchronizer for the read Gray pointer
	always_ff @(posedge i_wclk or negedge i_wrst_n) begin
		if (!i_wrst_n) begin
			wq1_rgray <= '0;
			wq2_rgray <= '0;
		end else begin
			wq1_rgray <= rgray;
			wq2_rgray <= wq1_rgray;
		end
	end

	// Full when the writer sits one lap ahead of the reader.
	// In Gray code that shows as the two top bits flipped and the rest equal
	always_ff @(posedge i_wclk or negedge i_wrst_n) begin
		if (!i_wrst_n) begin
			o_wfull <= 1'b0;
		end else begin
			o_wfull <= (wgray_next == {~wq2_rgray[AW:AW-1], wq2_rgray[AW-2:0]});
		end
	end

	always_ff @(posedge i_wclk) begin
		if (wr_ok) begin
			mem[wbin[AW-1:0]] <= i_wdata;
		end
	end

	////////////////////
	// Read domain
	////////////////////

	// A pop from an empty FIFO is ignored
	assign rd_ok = i_rd && !o_rempty;

	assign rbin_next  = rbin + {{AW{1'b0}}, rd_ok};
	assign rgray_next = (rbin_next >> 1) ^ rbin_next;

	always_ff @(posedge i_rclk or negedge i_rrst_n) begin
		if (!i_rrst_n) begin
			rbin  <= '0;
			rgray <= '0;
		end else begin
			rbin  <= rbin_next;
			rgray <= rgray_next;
		end
	end

	// Two flop synchronizer for the write Gray pointer
	always_ff @(posedge i_rclk or negedge i_rrst_n) begin
		if (!i_rrst_n) begin
			rq1_wgray <= '0;
			rq2_wgray <= '0;
		end else begin
			rq1_wgray <= wgray;
			rq2_wgray <= rq1_wgray;
		end
	end

	// Empty once the reader has caught up with the synchronized writer
	always_ff @(posedge i_rclk or negedge i_rrst_n) begin
		if (!i_rrst_n) begin
			o_rempty <= 1'b1;
		end else begin
			o_rempty <= (rgray_next == rq2_wgray);
		end
	end

	// The head of the queue goes out combinationally
	assign o_rdata = mem[rbin[AW-1:0]];

endmodule

// File: common/mbox_pkg.sv
package mbox_pkg;

	////////////////////
	// Widths
	////////////////////

	// Data word carried in both directions
	localparam int MBOX_DW = 32;

	// Byte address width of the register window
	localparam int MBOX_AW = 8;

	// Each FIFO holds 1 << FIFO_AW entries
	localparam int FIFO_AW = 4;

	////////////////////
	// Register map
	////////////////////

	// Live FIFO flags, read only
	localparam logic [MBOX_AW-1:0] ADDR_STATUS = 8'h00;
	// Push with last clear, write only
	localparam logic [MBOX_AW-1:0] ADDR_TXDATA = 8'h04;
	// Push with last set, write only
	localparam logic [MBOX_AW-1:0] ADDR_TXLAST = 8'h08;
	// Pop one received word, read only
	localparam logic [MBOX_AW-1:0] ADDR_RXDATA = 8'h0C;

	// AXI response encodings
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	// Bit positions inside the status word, all other bits read as zero
	localparam int STAT_TX_FULL  = 0;
	localparam int STAT_RX_EMPTY = 1;

	////////////////////
	// FIFO payloads
	////////////////////

	// Host to stream word, last marks the end of a packet
	typedef struct packed {
		logic               last;
		logic [MBOX_DW-1:0] data;
	} tx_word_t;

	// Stream to host word
	typedef struct packed {
		logic [MBOX_DW-1:0] data;
	} rx_word_t;

endpackage

// File: hdl/mbox_axil_regs.sv
module mbox_axil_regs import mbox_pkg::*; (
	input  logic               i_wclk,
	input  logic               i_rrst_n,
	// AXI4-Lite write address and data
	input  logic               i_s_awvalid,
	output logic               o_s_awready,
	input  logic [MBOX_AW-1:0] i_s_awaddr,
	input  logic               i_s_wvalid,
	output logic               o_s_wready,
	input  logic [MBOX_DW-1:0] i_s_wdata,
	input  logic [3:0]         i_s_wstrb,
	// AXI4-Lite write response
	output logic               o_s_bvalid,
	input  logic               i_s_bready,
	output logic [1:0]         o_s_bresp,
	// AXI4-Lite read address and data
	input  logic               i_s_arvalid,
	output logic               o_s_arready,
	input  logic [MBOX_AW-1:0] i_s_araddr,
	output logic               o_s_rvalid,
	input  logic               i_s_rready,
	output logic [MBOX_DW-1:0] o_s_rdata,
	output logic [1:0]         o_s_rresp,
	// Transmit FIFO write port
	output logic               o_tx_push,
	output tx_word_t           o_tx_word,
	input  logic               i_tx_full,
	// Receive FIFO read port
	output logic               o_rx_pop,
	input  rx_word_t           i_rx_word,
	input  logic               i_rx_empty
);

	logic               wr_hs;
	logic               wr_to_tx;
	logic [1:0]         wr_resp;
	logic               rd_hs;
	logic [MBOX_DW-1:0] rd_data;
	logic [1:0]         rd_resp;
	logic [MBOX_DW-1:0] status_word;

	////////////////////
	// Write channel
	////////////////////

	// Address and data are taken together, one cycle after both are valid.
	// The own-ready term keeps the pulse to a single cycle
	always_ff @(posedge i_wclk or negedge i_rrst_n) begin
		if (!i_rrst_n) begin
			o_s_awready <= 1'b0;
		end else begin
			o_s_awready <= i_s_awvalid && i_s_wvalid && !o_s_awready && !o_s_bvalid;
		end
	end

	assign o_s_wready = o_s_awready;

	// The master still holds both valids while ready is high
	assign wr_hs = o_s_awready && i_s_awvalid && i_s_wvalid;

	assign wr_to_tx = (i_s_awaddr == ADDR_TXDATA) || (i_s_awaddr == ADDR_TXLAST);

	// Every push carries the whole data word whatever the byte strobes say
	assign o_tx_word.last = (i_s_awaddr == ADDR_TXLAST);
	assign o_tx_word.data = i_s_wdata;

	// The full flag is current here since writes are three or more cycles apart
	assign o_tx_push = wr_hs && wr_to_tx && !i_tx_full;

	always_comb begin
		if (!wr_to_tx) begin
			wr_resp = RESP_DECERR;
		end else if (i_tx_full) begin
			wr_resp = RESP_SLVERR;
		end else begin
			wr_resp = RESP_OKAY;
		end
	end

	always_ff @(posedge i_wclk or negedge i_rrst_n) begin
		if (!i_rrst_n) begin
			o_s_bvalid <= 1'b0;
		end else if (wr_hs) begin
			o_s_bvalid <= 1'b1;
		end else if (i_s_bready) begin
			o_s_bvalid <= 1'b0;
		end
	end

	// Response code stays put while bvalid waits for bready
	always_ff @(posedge i_wclk) begin
		if (wr_hs) begin
			o_s_bresp <= wr_resp;
		end
	end

	////////////////////
	// Read channel
	////////////////////

	always_ff @(posedge i_wclk or negedge i_rrst_n) begin
		if (!i_rrst_n) begin
			o_s_arready <= 1'b0;
		end else begin
			o_s_arready <= i_s_arvalid && !o_s_arready && !o_s_rvalid;
		end
	end

	assign rd_hs = o_s_arready && i_s_arvalid;

	// Pop in the same cycle the head word is captured below
	assign o_rx_pop = rd_hs && (i_s_araddr == ADDR_RXDATA) && !i_rx_empty;

	// Live flags with all unused bits at zero
	always_comb begin
		status_word = '0;
		status_word[STAT_TX_FULL]  = i_tx_full;
		status_word[STAT_RX_EMPTY] = i_rx_empty;
	end

	always_comb begin
		rd_data = '0;
		rd_resp = RESP_DECERR;
		case (i_s_araddr)
			ADDR_STATUS: begin
				rd_data = status_word;
				rd_resp = RESP_OKAY;
			end
			ADDR_RXDATA: begin
				// With nothing to pop the answer is zero with an error
				if (i_rx_empty) begin
					rd_resp = RESP_SLVERR;
				end else begin
					rd_data = i_rx_word.data;
					rd_resp = RESP_OKAY;
				end
			end
			default: begin
				rd_resp = RESP_DECERR;
			end
		endcase
	end

	always_ff @(posedge i_wclk or negedge i_rrst_n) begin
		if (!i_rrst_n) begin
			o_s_rvalid <= 1'b0;
		end else if (rd_hs) begin
			o_s_rvalid <= 1'b1;
		end else if (i_s_rready) begin
			o_s_rvalid <= 1'b0;
		end
	end

	// Data and response held stable until rready
	always_ff @(posedge i_wclk) begin
		if (rd_hs) begin
			o_s_rdata <= rd_data;
			o_s_rresp <= rd_resp;
		end
	end

endmodule

// File: hdl/mbox_top.sv
module mbox_top import mbox_pkg::*; (
	input  logic               i_wclk,
	input  logic               i_rclk,
	input  logic               i_rrst_n,
	// AXI4-Lite slave, i_wclk domain
	input  logic               i_s_awvalid,
	output logic               o_s_awready,
	input  logic [MBOX_AW-1:0] i_s_awaddr,
	input  logic               i_s_wvalid,
	output logic               o_s_wready,
	input  logic [MBOX_DW-1:0] i_s_wdata,
	input  logic [3:0]         i_s_wstrb,
	output logic               o_s_bvalid,
	input  logic               i_s_bready,
	output logic [1:0]         o_s_bresp,
	input  logic               i_s_arvalid,
	output logic               o_s_arready,
	input  logic [MBOX_AW-1:0] i_s_araddr,
	output logic               o_s_rvalid,
	input  logic               i_s_rready,
	output logic [MBOX_DW-1:0] o_s_rdata,
	output logic [1:0]         o_s_rresp,
	// Transmit stream, i_rclk domain
	output logic               o_tx_valid,
	input  logic               i_tx_ready,
	output logic [MBOX_DW-1:0] o_tx_data,
	output logic               o_tx_last,
	// Receive stream, i_rclk domain
	input  logic               i_rx_valid,
	output logic               o_rx_ready,
	input  logic [MBOX_DW-1:0] i_rx_data
);

	logic     tx_push;
	tx_word_t tx_wword;
	logic     tx_full;
	tx_word_t tx_head;
	logic     tx_empty;

	logic     rx_pop;
	rx_word_t rx_wword;
	rx_word_t rx_head;
	logic     rx_full;
	logic     rx_empty;

	mbox_axil_regs u_regs (
		.i_wclk      (i_wclk),
		.i_rrst_n    (i_rrst_n),
		.i_s_awvalid (i_s_awvalid),
		.o_s_awready (o_s_awready),
		.i_s_awaddr  (i_s_awaddr),
		.i_s_wvalid  (i_s_wvalid),
		.o_s_wready  (o_s_wready),
		.i_s_wdata   (i_s_wdata),
		.i_s_wstrb   (i_s_wstrb),
		.o_s_bvalid  (o_s_bvalid),
		.i_s_bready  (i_s_bready),
		.o_s_bresp   (o_s_bresp),
		.i_s_arvalid (i_s_arvalid),
		.o_s_arready (o_s_arready),
		.i_s_araddr  (i_s_araddr),
		.o_s_rvalid  (o_s_rvalid),
		.i_s_rready  (i_s_rready),
		.o_s_rdata   (o_s_rdata),
		.o_s_rresp   (o_s_rresp),
		.o_tx_push   (tx_push),
		.o_tx_word   (tx_wword),
		.i_tx_full   (tx_full),
		.o_rx_pop    (rx_pop),
		.i_rx_word   (rx_head),
		.i_rx_empty  (rx_empty)
	);

	////////////////////
	// Host to stream
	////////////////////

	// The FIFO ignores a read while empty, so ready alone can drive the pop
	afifo #(
		.T_PAYLOAD (tx_word_t),
		.AW        (FIFO_AW)
	) u_tx_fifo (
		.i_wclk   (i_wclk),
		.i_wrst_n (i_rrst_n),
		.i_wr     (tx_push),
		.i_wdata  (tx_wword),
		.o_wfull  (tx_full),
		.i_rclk   (i_rclk),
		.i_rrst_n (i_rrst_n),
		.i_rd     (i_tx_ready),
		.o_rdata  (tx_head),
		.o_rempty (tx_empty)
	);

	assign o_tx_valid = !tx_empty;
	assign o_tx_data  = tx_head.data;
	assign o_tx_last  = tx_head.last;

	////////////////////
	// Stream to host
	////////////////////

	assign rx_wword.data = i_rx_data;
	assign o_rx_ready    = !rx_full;

	// A write while full is dropped inside, and ready is low then anyway
	afifo #(
		.T_PAYLOAD (rx_word_t),
		.AW        (FIFO_AW)
	) u_rx_fifo (
		.i_wclk   (i_rclk),
		.i_wrst_n (i_rrst_n),
		.i_wr     (i_rx_valid),
		.i_wdata  (rx_wword),
		.o_wfull  (rx_full),
		.i_rclk   (i_wclk),
		.i_rrst_n (i_rrst_n),
		.i_rd     (rx_pop),
		.o_rdata  (rx_head),
		.o_rempty (rx_empty)
	);

endmodule

// File: mbox_top.f
common/mbox_pkg.sv
cdc_fifo/afifo.sv
hdl/mbox_axil_regs.sv
hdl/mbox_top.sv
verif/mbox_tb.sv

// File: verif/mbox_tb.sv
module mbox_tb import mbox_pkg::*; ();

	// Table operations cover AXI accesses plus stream and pin actions
	typedef enum logic [2:0] {
		OP_WR,
		OP_RD,
		OP_PINS,
		OP_RXPUT,
		OP_RXWAIT,
		OP_HOLD,
		OP_DRAIN,
		OP_END
	} op_e;

	typedef struct packed {
		op_e                op;
		logic [MBOX_AW-1:0] addr;
		logic [MBOX_DW-1:0] data;
		logic [MBOX_DW-1:0] exp_data;
		logic [1:0]         exp_resp;
	} step_t;

	logic               i_wclk;
	logic               i_rclk;
	logic               i_rrst_n;
	logic               i_s_awvalid;
	logic               o_s_awready;
	logic [MBOX_AW-1:0] i_s_awaddr;
	logic               i_s_wvalid;
	logic               o_s_wready;
	logic [MBOX_DW-1:0] i_s_wdata;
	logic [3:0]         i_s_wstrb;
	logic               o_s_bvalid;
	logic               i_s_bready;
	logic [1:0]         o_s_bresp;
	logic               i_s_arvalid;
	logic               o_s_arready;
	logic [MBOX_AW-1:0] i_s_araddr;
	logic               o_s_rvalid;
	logic               i_s_rready;
	logic [MBOX_DW-1:0] o_s_rdata;
	logic [1:0]         o_s_rresp;
	logic               o_tx_valid;
	logic               i_tx_ready;
	logic [MBOX_DW-1:0] o_tx_data;
	logic               o_tx_last;
	logic               i_rx_valid;
	logic               o_rx_ready;
	logic [MBOX_DW-1:0] i_rx_data;

	step_t              steps [0:63];
	int                 step_count;
	int                 wait_limit = 1000;
	int                 errors;
	int                 test_errs;
	int                 checks;
	int                 tests_run;
	int                 tests_failed;
	logic [31:0]        lfsr_state;
	logic               tx_hold;
	logic [MBOX_DW:0]   tx_exp_q [$];
	logic [MBOX_DW:0]   tx_rcv_q [$];
	logic [MBOX_DW-1:0] rx_src_q [$];

	mbox_top dut0 (.*);

	////////////////////
	// Clocks and stream models
	////////////////////

	always #4 i_wclk = ~i_wclk;

	// Period 13 keeps this clock unrelated to the host clock
	always begin
		#7 i_rclk = 1'b1;
		#6 i_rclk = 1'b0;
	end

	// Right shift Galois form with taps at 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	// Sink back-pressure takes one LFSR bit per cycle unless held off
	always @(posedge i_rclk) begin
		#1;
		if (tx_hold) begin
			i_tx_ready = 1'b0;
		end else begin
			i_tx_ready = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	end

	// Values seen here are the ones from before the edge
	always @(posedge i_rclk) begin
		if (i_rrst_n && o_tx_valid && i_tx_ready) begin
			tx_rcv_q.push_back({o_tx_last, o_tx_data});
		end
	end

	// Source keeps the head word on the bus until the FIFO takes it
	always @(posedge i_rclk) begin
		if (i_rx_valid && o_rx_ready) begin
			void'(rx_src_q.pop_front());
		end
		#1;
		if (rx_src_q.size() > 0) begin
			i_rx_valid = 1'b1;
			i_rx_data  = rx_src_q[0];
		end else begin
			i_rx_valid = 1'b0;
			i_rx_data  = '0;
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic abort_run(input string why);
		$display("ERROR at %0t: %s", $time, why);
		$display("*** FAILED ***");
		$finish;
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH @%0t: %s got %h, expected %h", $time, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	// Address and data go out together and stay until the slave takes them
	task automatic axi_write(input logic [MBOX_AW-1:0] addr, input logic [MBOX_DW-1:0] data,
			output logic [1:0] resp);
		int n;
		@(posedge i_wclk);
		#1;
		i_s_awvalid = 1'b1;
		i_s_awaddr  = addr;
		i_s_wvalid  = 1'b1;
		i_s_wdata   = data;
		i_s_bready  = 1'b1;
		n = 0;
		do begin
			@(negedge i_wclk);
			n++;
			if (n > wait_limit) abort_run("write address was never accepted");
		end while (!o_s_awready);
		// Data is taken in the same cycle as the address
		check_value({31'b0, o_s_wready}, 32'h1, "write data ready");
		@(posedge i_wclk);
		#1;
		i_s_awvalid = 1'b0;
		i_s_wvalid  = 1'b0;
		n = 0;
		while (!o_s_bvalid) begin
			@(negedge i_wclk);
			n++;
			if (n > wait_limit) abort_run("write response never came");
		end
		resp = o_s_bresp;
		@(posedge i_wclk);
		#1;
		i_s_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [MBOX_AW-1:0] addr, output logic [MBOX_DW-1:0] data,
			output logic [1:0] resp);
		int n;
		@(posedge i_wclk);
		#1;
		i_s_arvalid = 1'b1;
		i_s_araddr  = addr;
		i_s_rready  = 1'b1;
		n = 0;
		do begin
			@(negedge i_wclk);
			n++;
			if (n > wait_limit) abort_run("read address was never accepted");
		end while (!o_s_arready);
		@(posedge i_wclk);
		#1;
		i_s_arvalid = 1'b0;
		n = 0;
		while (!o_s_rvalid) begin
			@(negedge i_wclk);
			n++;
			if (n > wait_limit) abort_run("read data never came");
		end
		data = o_s_rdata;
		resp = o_s_rresp;
		@(posedge i_wclk);
		#1;
		i_s_rready = 1'b0;
	endtask

	// Compare everything the sink saw against what the host pushed
	task automatic drain_tx();
		logic [MBOX_DW:0] got;
		logic [MBOX_DW:0] exp;
		int               n;
		n = 0;
		while (tx_rcv_q.size() < tx_exp_q.size()) begin
			@(negedge i_wclk);
			n++;
			if (n > wait_limit) abort_run("transmit stream words never arrived");
		end
		// Leave room for a stray extra word to show up
		repeat (40) @(negedge i_wclk);
		check_value(tx_rcv_q.size(), tx_exp_q.size(), "transmit word count");
		while (tx_exp_q.size() > 0 && tx_rcv_q.size() > 0) begin
			exp = tx_exp_q.pop_front();
			got = tx_rcv_q.pop_front();
			check_value(got[MBOX_DW-1:0], exp[MBOX_DW-1:0], "transmit data");
			check_value({31'b0, got[MBOX_DW]}, {31'b0, exp[MBOX_DW]}, "transmit last");
		end
		tx_exp_q.delete();
		tx_rcv_q.delete();
	endtask

	// Waits until the source has handed over every word and the host sees one
	task automatic wait_rx_data();
		logic [MBOX_DW-1:0] stat;
		logic [1:0]         resp;
		int                 n;
		n = 0;
		while (rx_src_q.size() != 0) begin
			@(negedge i_wclk);
			n++;
			if (n > wait_limit) abort_run("receive stream source never drained");
		end
		n = 0;
		do begin
			axi_read(ADDR_STATUS, stat, resp);
			n++;
			if (n > wait_limit) abort_run("receive FIFO never reported data");
		end while (stat[STAT_RX_EMPTY]);
	endtask

	function automatic string test_name(input int id);
		case (id)
			1:       return "reset state";
			2:       return "transmit order and last";
			3:       return "receive order and empty read";
			4:       return "transmit full and drop";
			5:       return "decode errors";
			default: return "unknown";
		endcase
	endfunction

	////////////////////
	// Stimulus table
	////////////////////

	task automatic add_step(input op_e op, input logic [MBOX_AW-1:0] addr,
			input logic [MBOX_DW-1:0] data, input logic [MBOX_DW-1:0] exp_data,
			input logic [1:0] exp_resp);
		steps[step_count] = '{op, addr, data, exp_data, exp_resp};
		step_count++;
	endtask

	task automatic build_steps();
		logic [MBOX_AW-1:0] addr;
		step_count = 0;
		// Receive FIFO empty, transmit FIFO not full, rx_ready high, tx_valid low
		add_step(OP_PINS, '0, '0, 32'h2, RESP_OKAY);
		add_step(OP_RD, ADDR_STATUS, '0, 32'h2, RESP_OKAY);
		add_step(OP_END, '0, 1, '0, RESP_OKAY);
		add_step(OP_WR, ADDR_TXDATA, 32'h1111_0001, '0, RESP_OKAY);
		add_step(OP_WR, ADDR_TXDATA, 32'hdead_beef, '0, RESP_OKAY);
		add_step(OP_WR, ADDR_TXLAST, 32'h0000_0003, '0, RESP_OKAY);
		add_step(OP_WR, ADDR_TXDATA, 32'h8000_0000, '0, RESP_OKAY);
		add_step(OP_WR, ADDR_TXLAST, 32'hffff_ffff, '0, RESP_OKAY);
		add_step(OP_DRAIN, '0, '0, '0, RESP_OKAY);
		add_step(OP_END, '0, 2, '0, RESP_OKAY);
		add_step(OP_RXPUT, '0, 32'h5a5a_0001, '0, RESP_OKAY);
		add_step(OP_RXPUT, '0, 32'h0000_0002, '0, RESP_OKAY);
		add_step(OP_RXPUT, '0, 32'hcafe_f00d, '0, RESP_OKAY);
		add_step(OP_RXWAIT, '0, '0, '0, RESP_OKAY);
		add_step(OP_RD, ADDR_RXDATA, '0, 32'h5a5a_0001, RESP_OKAY);
		add_step(OP_RD, ADDR_RXDATA, '0, 32'h0000_0002, RESP_OKAY);
		add_step(OP_RD, ADDR_RXDATA, '0, 32'hcafe_f00d, RESP_OKAY);
		add_step(OP_RD, ADDR_RXDATA, '0, '0, RESP_SLVERR);
		add_step(OP_END, '0, 3, '0, RESP_OKAY);
		// Sixteen words fill the FIFO while the sink is stalled
		add_step(OP_HOLD, '0, 1, '0, RESP_OKAY);
		for (int i = 0; i < 16; i++) begin
			addr = (i % 4 == 3) ? ADDR_TXLAST : ADDR_TXDATA;
			add_step(OP_WR, addr, 32'hc0de_0000 + i, '0, RESP_OKAY);
		end
		add_step(OP_WR, ADDR_TXDATA, 32'hbad0_0017, '0, RESP_SLVERR);
		add_step(OP_RD, ADDR_STATUS, '0, 32'h3, RESP_OKAY);
		add_step(OP_HOLD, '0, 0, '0, RESP_OKAY);
		add_step(OP_DRAIN, '0, '0, '0, RESP_OKAY);
		add_step(OP_END, '0, 4, '0, RESP_OKAY);
		add_step(OP_WR, ADDR_STATUS, 32'h0000_00aa, '0, RESP_DECERR);
		add_step(OP_WR, 8'h10, 32'h0000_00bb, '0, RESP_DECERR);
		add_step(OP_RD, ADDR_TXDATA, '0, '0, RESP_DECERR);
		add_step(OP_RD, ADDR_STATUS, '0, 32'h2, RESP_OKAY);
		add_step(OP_RD, ADDR_RXDATA, '0, '0, RESP_SLVERR);
		add_step(OP_DRAIN, '0, '0, '0, RESP_OKAY);
		add_step(OP_END, '0, 5, '0, RESP_OKAY);
	endtask

	task automatic run_step(input step_t s);
		logic [MBOX_DW-1:0] got_data;
		logic [1:0]         got_resp;
		case (s.op)
			OP_WR: begin
				axi_write(s.addr, s.data, got_resp);
				check_value({30'b0, got_resp}, {30'b0, s.exp_resp}, "write response");
				// An accepted push must later show up on the stream
				if (s.exp_resp == RESP_OKAY &&
						(s.addr == ADDR_TXDATA || s.addr == ADDR_TXLAST)) begin
					tx_exp_q.push_back({s.addr == ADDR_TXLAST, s.data});
				end
			end
			OP_RD: begin
				axi_read(s.addr, got_data, got_resp);
				check_value(got_data, s.exp_data, "read data");
				check_value({30'b0, got_resp}, {30'b0, s.exp_resp}, "read response");
			end
			OP_PINS: begin
				@(negedge i_wclk);
				check_value({30'b0, o_rx_ready, o_tx_valid}, s.exp_data, "stream handshake pins");
			end
			OP_RXPUT: rx_src_q.push_back(s.data);
			OP_RXWAIT: wait_rx_data();
			OP_HOLD: tx_hold = s.data[0];
			OP_DRAIN: drain_tx();
			default: begin
				tests_run++;
				if (test_errs == 0) begin
					$display("test %0d %s: ok", s.data, test_name(s.data));
				end else begin
					$display("test %0d %s: %0d errors", s.data, test_name(s.data), test_errs);
					tests_failed++;
				end
				test_errs = 0;
			end
		endcase
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		i_wclk      = 1'b0;
		i_rclk      = 1'b0;
		i_rrst_n    = 1'b0;
		i_s_awvalid = 1'b0;
		i_s_awaddr  = '0;
		i_s_wvalid  = 1'b0;
		i_s_wdata   = '0;
		i_s_wstrb   = 4'hf;
		i_s_bready  = 1'b0;
		i_s_arvalid = 1'b0;
		i_s_araddr  = '0;
		i_s_rready  = 1'b0;
		i_tx_ready  = 1'b0;
		i_rx_valid  = 1'b0;
		i_rx_data   = '0;
		lfsr_state  = 32'h2baef710;
		tx_hold     = 1'b0;
		errors       = 0;
		test_errs    = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		build_steps();
		repeat (3) @(posedge i_wclk);
		#1;
		i_rrst_n = 1'b1;
		for (int i = 0; i < step_count; i++) begin
			run_step(steps[i]);
		end
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
